//--- hdl/rd_router_defines.svh
`ifndef RD_ROUTER_DEFINES_SVH
`define RD_ROUTER_DEFINES_SVH

// ----------------------------------------------------------
// Read router sizing
// ----------------------------------------------------------

// Stream data width in bits
`define RR_DATA_BITS 64

// Number of user clients
`define RR_N_CPID 4

// Virtual address width
`define RR_ADDR_BITS 32

// Request length field, bytes
`define RR_LEN_BITS 16

// Process id carried in tid
`define RR_PID_BITS 6

// Outstanding routing commands
`define RR_CMD_DEPTH 4

`endif

//--- hdl/rd_router_pkg.sv
`default_nettype none

`include "rd_router_defines.svh"

package rd_router_pkg;

  // Bytes per stream beat
  localparam int BEAT_BYTES = `RR_DATA_BITS / 8;
  // Client index width
  localparam int CPID_BITS = $clog2(`RR_N_CPID);
  // Beat count field width
  localparam int BLEN_BITS = `RR_LEN_BITS - $clog2(BEAT_BYTES);

  // Client read request, len is at least 1 byte
  typedef struct packed {
    logic [`RR_ADDR_BITS-1:0] vaddr;
    logic [`RR_LEN_BITS-1:0]  len;
    logic [`RR_PID_BITS-1:0]  pid;
  } rd_req_t;

  // Request towards memory, tagged with granted client
  typedef struct packed {
    logic [CPID_BITS-1:0] cpid;
    rd_req_t              req;
  } mem_req_t;

  // Routing command, blen is beats minus one
  typedef struct packed {
    logic [CPID_BITS-1:0] cpid;
    logic [BLEN_BITS-1:0] blen;
  } mux_cmd_t;

  // One beat of the read data stream
  typedef struct packed {
    logic [`RR_DATA_BITS-1:0] tdata;
    logic [BEAT_BYTES-1:0]    tkeep;
    logic [`RR_PID_BITS-1:0]  tid;
    logic                     tlast;
  } axis_beat_t;

endpackage

`default_nettype wire

//--- hdl/rd_req_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "rd_router_defines.svh"

module rd_req_arbiter (
  input  logic                                    aclk,
  input  logic                                    aresetn,
  input  logic [`RR_N_CPID-1:0]                   req_valid,
  input  rd_router_pkg::rd_req_t [`RR_N_CPID-1:0] req,
  output logic [`RR_N_CPID-1:0]                   req_ready,
  output logic                                    mem_req_valid,
  output rd_router_pkg::mem_req_t                 mem_req,
  input  logic                                    mem_req_ready,
  output logic                                    push_valid,
  output rd_router_pkg::mux_cmd_t                 push_cmd,
  input  logic                                    push_ready
);

  import rd_router_pkg::*;

  // Byte offset bits inside one beat
  localparam int BEAT_LOG = $clog2(BEAT_BYTES);

  // First client searched next cycle
  logic [CPID_BITS-1:0]    rr_next;
  // Search result
  logic [CPID_BITS-1:0]    gnt_idx;
  logic                    gnt_found;
  // Output stage empty or draining
  logic                    out_free;
  logic                    grant;
  logic [`RR_LEN_BITS-1:0] len_m1;

  // ----------------------------------------------------------
  // Round-robin search
  // ----------------------------------------------------------

  // Scan from rr_next, wrap around, first requester wins
  always_comb begin : rr_search
    int idx;
    gnt_found = 1'b0;
    gnt_idx   = rr_next;
    for (int i = 0; i < `RR_N_CPID; i++) begin
      idx = (int'(rr_next) + i) % `RR_N_CPID;
      if (!gnt_found && req_valid[idx]) begin
        gnt_found = 1'b1;
        gnt_idx   = CPID_BITS'(idx);
      end
    end
  end

  // Grant needs a free output slot and FIFO room
  assign out_free = !mem_req_valid || mem_req_ready;
  assign grant    = gnt_found && out_free && push_ready;

  // One-hot ready to the winner only
  always_comb begin
    req_ready = '0;
    if (grant) begin
      req_ready[gnt_idx] = 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Routing command
  // ----------------------------------------------------------

  // Beats minus one = (len - 1) / BEAT_BYTES
  assign len_m1        = req[gnt_idx].len - 1'b1;
  assign push_valid    = grant;
  assign push_cmd.cpid = gnt_idx;
  assign push_cmd.blen = len_m1[`RR_LEN_BITS-1:BEAT_LOG];

  // Pointer moves past the granted client
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rr_next <= '0;
    end else if (grant) begin
      rr_next <= (gnt_idx == CPID_BITS'(`RR_N_CPID - 1)) ? '0 : gnt_idx + 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Memory request output stage
  // ----------------------------------------------------------

  // Valid flag, held while memory stalls
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      mem_req_valid <= 1'b0;
    end else if (grant) begin
      mem_req_valid <= 1'b1;
    end else if (mem_req_ready) begin
      mem_req_valid <= 1'b0;
    end
  end

  // Payload, loaded on grant only
  always_ff @(posedge aclk) begin
    if (grant) begin
      mem_req.cpid <= gnt_idx;
      mem_req.req  <= req[gnt_idx];
    end
  end

endmodule

`default_nettype wire

//--- hdl/mux_cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "rd_router_defines.svh"

module mux_cmd_fifo #(
  parameter int DEPTH = `RR_CMD_DEPTH
) (
  input  logic                    aclk,
  input  logic                    aresetn,
  input  logic                    push_valid,
  input  rd_router_pkg::mux_cmd_t push_cmd,
  output logic                    push_ready,
  output logic                    cmd_valid,
  output rd_router_pkg::mux_cmd_t cmd,
  input  logic                    cmd_ready
);

  import rd_router_pkg::*;

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  // Command storage
  mux_cmd_t            mem [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  // Entries held
  logic [CNT_BITS-1:0] count;
  logic                do_push;
  logic                do_pop;

  // ----------------------------------------------------------
  // Status and handshakes
  // ----------------------------------------------------------

  assign push_ready = (count != CNT_BITS'(DEPTH));
  assign cmd_valid  = (count != '0);
  assign do_push    = push_valid && push_ready;
  assign do_pop     = cmd_valid && cmd_ready;

  // Head entry straight from storage
  assign cmd = mem[rd_ptr];

  // ----------------------------------------------------------
  // Storage and pointers
  // ----------------------------------------------------------

  always_ff @(posedge aclk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_cmd;
    end
  end

  // Pointers wrap at DEPTH-1
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // Count holds when push and pop coincide
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      count <= '0;
    end else begin
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/user_mux_rd.sv
`timescale 1ns/1ps
`default_nettype none

`include "rd_router_defines.svh"

module user_mux_rd (
  input  logic                                       aclk,
  input  logic                                       aresetn,
  input  logic                                       cmd_valid,
  input  rd_router_pkg::mux_cmd_t                    cmd,
  output logic                                       cmd_ready,
  input  logic                                       s_valid,
  input  rd_router_pkg::axis_beat_t                  s_beat,
  output logic                                       s_ready,
  output logic [`RR_N_CPID-1:0]                      m_valid,
  output rd_router_pkg::axis_beat_t [`RR_N_CPID-1:0] m_beat,
  input  logic [`RR_N_CPID-1:0]                      m_ready
);

  import rd_router_pkg::*;

  // FSM
  typedef enum logic [0:0] {ST_IDLE, ST_MUX} state_t;
  state_t state_q;
  state_t state_d;

  // Selected client and beats left minus one
  logic [CPID_BITS-1:0] cpid_q;
  logic [CPID_BITS-1:0] cpid_d;
  logic [BLEN_BITS-1:0] cnt_q;
  logic [BLEN_BITS-1:0] cnt_d;

  logic beat_xfer;
  // Last beat of burst handshaked
  logic tr_done;

  // ----------------------------------------------------------
  // Stream routing
  // ----------------------------------------------------------

  // Payload to every client, valid to the selected one
  always_comb begin
    for (int i = 0; i < `RR_N_CPID; i++) begin
      m_beat[i]  = s_beat;
      m_valid[i] = (state_q == ST_MUX) && (cpid_q == CPID_BITS'(i)) && s_valid;
    end
    s_ready = (state_q == ST_MUX) ? m_ready[cpid_q] : 1'b0;
  end

  assign beat_xfer = s_valid && s_ready;
  assign tr_done   = beat_xfer && (cnt_q == '0);

  // ----------------------------------------------------------
  // Command sequencing
  // ----------------------------------------------------------

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= ST_IDLE;
      cpid_q  <= '0;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cpid_q  <= cpid_d;
      cnt_q   <= cnt_d;
    end
  end

  // Next state and datapath
  always_comb begin
    state_d   = state_q;
    cpid_d    = cpid_q;
    cnt_d     = cnt_q;
    cmd_ready = 1'b0;

    case (state_q)
      ST_IDLE: begin
        if (cmd_valid) begin
          cmd_ready = 1'b1;
          cpid_d    = cmd.cpid;
          cnt_d     = cmd.blen;
          state_d   = ST_MUX;
        end
      end

      ST_MUX: begin
        if (tr_done) begin
          // Chain next burst without a bubble
          if (cmd_valid) begin
            cmd_ready = 1'b1;
            cpid_d    = cmd.cpid;
            cnt_d     = cmd.blen;
          end else begin
            state_d = ST_IDLE;
          end
        end else if (beat_xfer) begin
          cnt_d = cnt_q - 1'b1;
        end
      end

      default: state_d = ST_IDLE;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/rd_router_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rd_router_defines.svh"

module rd_router_top (
  input  logic                                       aclk,
  input  logic                                       aresetn,
  // Client requests
  input  logic [`RR_N_CPID-1:0]                      req_valid,
  output logic [`RR_N_CPID-1:0]                      req_ready,
  input  rd_router_pkg::rd_req_t [`RR_N_CPID-1:0]    req,
  // Memory request
  output logic                                       mem_req_valid,
  input  logic                                       mem_req_ready,
  output rd_router_pkg::mem_req_t                    mem_req,
  // Memory read stream
  input  logic                                       s_valid,
  output logic                                       s_ready,
  input  rd_router_pkg::axis_beat_t                  s_beat,
  // Client read streams
  output logic [`RR_N_CPID-1:0]                      m_valid,
  input  logic [`RR_N_CPID-1:0]                      m_ready,
  output rd_router_pkg::axis_beat_t [`RR_N_CPID-1:0] m_beat
);

  import rd_router_pkg::*;

  // ----------------------------------------------------------
  // Command path, arbiter to demux
  // ----------------------------------------------------------

  logic     push_valid;
  logic     push_ready;
  mux_cmd_t push_cmd;
  logic     cmd_valid;
  logic     cmd_ready;
  mux_cmd_t cmd;

  // Merge client requests, tag with routing command
  rd_req_arbiter u_arb (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .req_valid     (req_valid),
    .req           (req),
    .req_ready     (req_ready),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_req_ready (mem_req_ready),
    .push_valid    (push_valid),
    .push_cmd      (push_cmd),
    .push_ready    (push_ready)
  );

  // Commands wait here while memory works
  mux_cmd_fifo #(
    .DEPTH (`RR_CMD_DEPTH)
  ) u_fifo (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .push_valid (push_valid),
    .push_cmd   (push_cmd),
    .push_ready (push_ready),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .cmd_ready  (cmd_ready)
  );

  // Route returning bursts to owners
  user_mux_rd u_mux (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .cmd_ready (cmd_ready),
    .s_valid   (s_valid),
    .s_beat    (s_beat),
    .s_ready   (s_ready),
    .m_valid   (m_valid),
    .m_beat    (m_beat),
    .m_ready   (m_ready)
  );

endmodule

`default_nettype wire

//--- test/tb_rd_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "rd_router_defines.svh"

module tb_rd_router;

  import rd_router_pkg::*;

  localparam int N       = `RR_N_CPID;
  localparam int TIMEOUT = 4000;

  logic                aclk;
  logic                aresetn;
  logic [N-1:0]        req_valid;
  logic [N-1:0]        req_ready;
  rd_req_t [N-1:0]     req;
  logic                mem_req_valid;
  logic                mem_req_ready;
  mem_req_t            mem_req;
  logic                s_valid;
  logic                s_ready;
  axis_beat_t          s_beat;
  logic [N-1:0]        m_valid;
  logic [N-1:0]        m_ready;
  axis_beat_t [N-1:0]  m_beat;

  // Stimulus modes sampled by the environment on the clock edge
  bit hold_data;
  bit mem_stall;
  bit rand_ready;
  // Memory stream must never stall while every client is ready
  bit strict_flow;

  // Memory model and scoreboard state
  logic [31:0] lfsr_state = 32'h006e_c8a6;
  mem_req_t    mreq_q[$];
  mem_req_t    cur;
  bit          busy;
  int          beat_k;
  int          cpid_log[$];
  axis_beat_t  exp_q[N][$];

  rd_router_top uut (.*);

  // 20 ns clock
  always #10 aclk = ~aclk;

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------

  // Galois LFSR stepped once per bit
  function automatic logic rand_bit();
    logic b;
    b          = lfsr_state[0];
    lfsr_state = {1'b0, lfsr_state[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], rand_bit()};
    end
    return v;
  endfunction

  function automatic int beats_for_len(input int len);
    return (len + BEAT_BYTES - 1) / BEAT_BYTES;
  endfunction

  // Beat k of a burst with the address word repeated and partial keep on the last beat
  function automatic axis_beat_t expected_beat(input rd_req_t r, input int k);
    axis_beat_t b;
    int         nb;
    int         rem;
    nb      = beats_for_len(int'(r.len));
    rem     = int'(r.len) - (nb - 1) * BEAT_BYTES;
    b.tdata = {(`RR_DATA_BITS / `RR_ADDR_BITS){r.vaddr + `RR_ADDR_BITS'(k * BEAT_BYTES)}};
    b.tid   = r.pid;
    b.tlast = (k == nb - 1);
    b.tkeep = b.tlast ? BEAT_BYTES'((1 << rem) - 1) : '1;
    return b;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_equal(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // Offer one request and queue its beats with an optional memory side check
  task automatic send_request(input int c, input logic [`RR_ADDR_BITS-1:0] vaddr,
                              input int len, input logic [`RR_PID_BITS-1:0] pid,
                              input bit check_mem);
    rd_req_t r;
    int      t;
    r.vaddr = vaddr;
    r.len   = `RR_LEN_BITS'(len);
    r.pid   = pid;
    for (int k = 0; k < beats_for_len(len); k++) begin
      exp_q[c].push_back(expected_beat(r, k));
    end
    req[c]       = r;
    req_valid[c] = 1'b1;
    t            = 0;
    @(posedge aclk);
    while (!req_ready[c]) begin
      t++;
      if (t > TIMEOUT) begin
        report_failure($sformatf("timeout: request of client %0d was never accepted", c));
      end
      @(posedge aclk);
    end
    // Output stage idle at the handshake
    if (check_mem) begin
      check_equal("mem_req_valid", mem_req_valid, 0);
    end
    #1;
    req_valid[c] = 1'b0;
    if (check_mem) begin
      @(posedge aclk);
      check_equal("mem_req_valid", mem_req_valid, 1);
      check_equal("mem_req.cpid", mem_req.cpid, c);
      check_equal("mem_req.req.vaddr", mem_req.req.vaddr, r.vaddr);
      check_equal("mem_req.req.len", mem_req.req.len, r.len);
      check_equal("mem_req.req.pid", mem_req.req.pid, r.pid);
      #1;
    end
  endtask

  // Every client issues its own sequence at once
  task automatic issue_all(input int per_client, input bit rnd);
    for (int c = 0; c < N; c++) begin
      fork
        automatic int cc = c;
        begin
          for (int j = 0; j < per_client; j++) begin
            if (rnd) begin
              send_request(cc, rand_bits(32), 1 + int'(rand_bits(6)),
                           `RR_PID_BITS'(rand_bits(6)), 1'b0);
            end else begin
              send_request(cc, 32'h0010_0000 * (cc + 1) + 32'h100 * j, 17 + 8 * j + cc,
                           `RR_PID_BITS'(cc + 8 * j), 1'b0);
            end
          end
        end
      join_none
    end
    wait fork;
  endtask

  task automatic wait_mem_requests(input int n);
    int t;
    t = 0;
    while (cpid_log.size() < n) begin
      @(posedge aclk);
      #1;
      t++;
      if (t > TIMEOUT) begin
        report_failure("timeout: memory never received the expected number of requests");
      end
    end
  endtask

  // Until memory is idle and every expected beat has arrived
  task automatic wait_drain();
    int t;
    int left;
    t    = 0;
    left = 1;
    while (left != 0) begin
      @(posedge aclk);
      #1;
      left = mreq_q.size() + int'(busy);
      for (int i = 0; i < N; i++) begin
        left += exp_q[i].size();
      end
      t++;
      if (t > TIMEOUT) begin
        report_failure("timeout: read data never drained to the clients");
      end
    end
  endtask

  // ----------------------------------------------------------
  // Memory model and client readiness
  // ----------------------------------------------------------

  always @(posedge aclk) begin : env
    bit run;
    bit xfer;
    bit hold_s;
    bit stall_s;
    bit rdy_s;
    run     = aresetn;
    xfer    = s_valid && s_ready;
    hold_s  = hold_data;
    stall_s = mem_stall;
    rdy_s   = rand_ready;
    if (run) begin
      if (mem_req_valid && mem_req_ready) begin
        mreq_q.push_back(mem_req);
        cpid_log.push_back(int'(mem_req.cpid));
      end
      if (strict_flow && s_valid && !s_ready) begin
        report_failure("memory stream stalled while every client was ready");
      end
      if (xfer) begin
        if (s_beat.tlast) begin
          busy = 1'b0;
        end else begin
          beat_k++;
        end
      end
    end
    #1;
    if (run) begin
      // Next burst right after tlast
      if (!busy && !hold_s && mreq_q.size() != 0) begin
        cur    = mreq_q.pop_front();
        busy   = 1'b1;
        beat_k = 0;
      end
      // Offered beat held until taken
      if (!s_valid || xfer) begin
        s_valid = busy && !(stall_s && rand_bit());
        if (s_valid) begin
          s_beat = expected_beat(cur.req, beat_k);
        end
      end
      mem_req_ready = stall_s ? rand_bit() : 1'b1;
      for (int i = 0; i < N; i++) begin
        m_ready[i] = rdy_s ? rand_bit() : 1'b1;
      end
    end
  end

  // Client sinks
  always @(posedge aclk) begin : sink
    axis_beat_t e;
    for (int i = 0; i < N; i++) begin
      if (aresetn && m_valid[i] && m_ready[i]) begin
        if (exp_q[i].size() == 0) begin
          report_failure($sformatf("client %0d received a beat it never asked for", i));
        end
        e = exp_q[i].pop_front();
        check_equal($sformatf("m_beat[%0d].tdata", i), m_beat[i].tdata, e.tdata);
        check_equal($sformatf("m_beat[%0d].tkeep", i), m_beat[i].tkeep, e.tkeep);
        check_equal($sformatf("m_beat[%0d].tid", i), m_beat[i].tid, e.tid);
        check_equal($sformatf("m_beat[%0d].tlast", i), m_beat[i].tlast, e.tlast);
      end
    end
  end

  // ----------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------

  task automatic reset_state();
    @(posedge aclk);
    check_equal("req_ready", req_ready, '0);
    check_equal("mem_req_valid", mem_req_valid, 0);
    check_equal("s_ready", s_ready, 0);
    check_equal("m_valid", m_valid, '0);
    #1;
  endtask

  // One read per client with beats only at that client
  task automatic single_reads();
    int len;
    strict_flow = 1'b1;
    for (int c = 0; c < N; c++) begin
      len = 1 + 13 * c;
      send_request(c, 32'h0001_0000 + 32'(c) * 32'h40, len, `RR_PID_BITS'(c + 1), 1'b0);
      wait_drain();
    end
    strict_flow = 1'b0;
  endtask

  task automatic request_latency();
    for (int c = 0; c < N; c++) begin
      send_request((3 * c + 1) % N, 32'h0002_0000 + 32'(c) * 32'h100, 8 * c + 3,
                   `RR_PID_BITS'(20 + c), 1'b1);
    end
    wait_drain();
  endtask

  // Grant order starts after the previous winner
  task automatic round_robin_order();
    int base;
    int last;
    for (int round = 0; round < 3; round++) begin
      base = cpid_log.size();
      last = cpid_log[base - 1];
      issue_all(1, 1'b0);
      wait_mem_requests(base + N);
      for (int k = 0; k < N; k++) begin
        check_equal("mem_req.cpid order", cpid_log[base + k], (last + 1 + k) % N);
      end
    end
    wait_drain();
  endtask

  task automatic back_to_back_bursts();
    strict_flow = 1'b1;
    issue_all(3, 1'b0);
    wait_drain();
    strict_flow = 1'b0;
  endtask

  task automatic random_backpressure();
    mem_stall  = 1'b1;
    rand_ready = 1'b1;
    issue_all(5, 1'b1);
    wait_drain();
    mem_stall  = 1'b0;
    rand_ready = 1'b0;
  endtask

  // Grants stop once the command path fills while data is withheld
  task automatic fifo_full_stall();
    int base;
    base      = cpid_log.size();
    hold_data = 1'b1;
    fork
      issue_all(2, 1'b0);
      begin
        // One command in the demux and the rest in the FIFO
        wait_mem_requests(base + 1 + `RR_CMD_DEPTH);
        repeat (8) begin
          @(posedge aclk);
          check_equal("req_ready", req_ready, '0);
          #1;
          check_equal("granted requests", cpid_log.size() - base, 1 + `RR_CMD_DEPTH);
        end
        hold_data = 1'b0;
      end
    join
    wait_drain();
  endtask

  initial begin
    aclk          = 1'b0;
    aresetn       = 1'b0;
    req_valid     = '0;
    req           = '0;
    mem_req_ready = 1'b0;
    s_valid       = 1'b0;
    s_beat        = '0;
    m_ready       = '0;
    hold_data     = 1'b0;
    mem_stall     = 1'b0;
    rand_ready    = 1'b0;
    strict_flow   = 1'b0;
    repeat (2) @(posedge aclk);
    #1;
    aresetn = 1'b1;
    reset_state();
    single_reads();
    request_latency();
    round_robin_order();
    back_to_back_bursts();
    random_backpressure();
    fifo_full_stall();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+hdl
hdl/rd_router_pkg.sv
hdl/rd_req_arbiter.sv
hdl/mux_cmd_fifo.sv
hdl/user_mux_rd.sv
hdl/rd_router_top.sv
test/tb_rd_router.sv

//--- Bender.yml
package:
  name: rd_router

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rd_router_pkg.sv
      - hdl/rd_req_arbiter.sv
      - hdl/mux_cmd_fifo.sv
      - hdl/user_mux_rd.sv
      - hdl/rd_router_top.sv

  - target: simulation
    include_dirs:
      - hdl
    files:
      - test/tb_rd_router.sv
